//--- Bender.yml
package:
  name: x1_core

sources:
  # design
  - files:
      - rtl/x1_pkg.sv
      - rtl/x1_clock_gen.sv
      - rtl/x1_spi_port.sv
      - rtl/x1_core_top.sv

  # verification
  - target: test
    files:
      - tb/x1_core_sva.sv
      - tb/x1_core_tb.sv

//--- build.f
rtl/x1_pkg.sv
rtl/x1_clock_gen.sv
rtl/x1_spi_port.sv
rtl/x1_core_top.sv
tb/x1_core_sva.sv
tb/x1_core_tb.sv

//--- rtl/x1_clock_gen.sv
// 32 MHz in, cpu clock is a level with 1-cycle strobes, not a real clock; ipl_n must be synchronous

`timescale 1ns/1ps

module x1_clock_gen
(
  input  logic clk32M,        // 32 MHz master clock
  input  logic clk_reset,     // board reset, async active high
  input  logic ipl_n,         // ipl key, low = pressed
  output logic sys_reset,     // stretched system reset
  output logic cpu_clk,       // 4 MHz cpu clock level
  output logic cpu_clk_rise,  // 1-cycle strobe before cpu_clk goes high
  output logic cpu_clk_fall,  // 1-cycle strobe before cpu_clk goes low
  output logic clk2m          // 2 MHz level for the sound timer
);

  logic [3:0] div_cnt;        // free running divider
  logic [3:0] phase_cnt;      // cpu phase counter, restarts on rise strobe
  logic [x1_pkg::reset_hold_w-1:0] hold_cnt;
  logic       reset_hold;     // stretched part of sys_reset

  // --------------------------------------------------
  // free running divider
  // --------------------------------------------------
  always_ff @(posedge clk32M or posedge clk_reset)
  begin
    if (clk_reset)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 4'd1;
  end

  assign clk2m = div_cnt[3];  // toggles every 8 cycles

  // --------------------------------------------------
  // cpu clock strobes
  // --------------------------------------------------
  // phase counter sits at 7 while the rise strobe is high, wraps to 0
  // on the next edge, so one cpu period is exactly 8 cycles
  always_ff @(posedge clk32M or posedge clk_reset)
  begin
    if (clk_reset)
    begin
      phase_cnt    <= '0;
      cpu_clk_rise <= 1'b0;
      cpu_clk_fall <= 1'b0;
      cpu_clk      <= 1'b0;
    end
    else
    begin
      if (cpu_clk_rise)
        phase_cnt <= '0;                   // restart period
      else
        phase_cnt <= phase_cnt + 4'd1;
      cpu_clk_rise <= (phase_cnt[2:0] == x1_pkg::clk_rise_phase);
      cpu_clk_fall <= (phase_cnt[2:0] == x1_pkg::clk_fall_phase);
      // level follows the strobes one cycle later
      if (cpu_clk_rise)
        cpu_clk <= 1'b1;
      else if (cpu_clk_fall)
        cpu_clk <= 1'b0;
    end
  end

  // --------------------------------------------------
  // reset stretcher
  // --------------------------------------------------
  always_ff @(posedge clk32M or posedge clk_reset)
  begin
    if (clk_reset)
    begin
      hold_cnt   <= '0;
      reset_hold <= 1'b1;
    end
    else if (reset_hold)
    begin
      hold_cnt <= hold_cnt + 1'b1;         // saturates, stops once released
      if (&hold_cnt)
        reset_hold <= 1'b0;                // released on the 16th edge
    end
  end

  // ipl key forces reset without waiting for a clock
  assign sys_reset = reset_hold | ~ipl_n;

endmodule : x1_clock_gen

//--- rtl/x1_core_top.sv
// clock front end plus card port only, io strobes come from outside as active high levels

`timescale 1ns/1ps

module x1_core_top
#(
  parameter logic [x1_pkg::addr_w-1:0] spi_base = x1_pkg::spi_io_base  // card port window
)
(
  // clock and reset
  input  logic                      clk32M,        // 32 MHz master clock
  input  logic                      clk_reset,     // board reset, async active high
  input  logic                      ipl_n,         // ipl key
  output logic                      sys_reset,     // stretched reset
  output logic                      cpu_clk,       // 4 MHz level
  output logic                      cpu_clk_rise,  // rise strobe
  output logic                      cpu_clk_fall,  // fall strobe
  output logic                      clk2m,         // 2 MHz level

  // io bus
  input  logic [x1_pkg::addr_w-1:0] io_addr,
  input  logic [x1_pkg::data_w-1:0] io_wdata,
  input  logic                      io_req,
  input  logic                      io_rd,
  input  logic                      io_wr,
  output logic [x1_pkg::data_w-1:0] io_rdata,

  // memory card pins
  output logic                      mmc_clk,
  output logic                      mmc_cs_n,
  output logic                      mmc_dout,
  input  logic                      mmc_din
);

  // --------------------------------------------------
  // clock and reset front end
  // --------------------------------------------------
  x1_clock_gen clock_gen_i
  (
    .clk32M       (clk32M),
    .clk_reset    (clk_reset),
    .ipl_n        (ipl_n),
    .sys_reset    (sys_reset),
    .cpu_clk      (cpu_clk),
    .cpu_clk_rise (cpu_clk_rise),
    .cpu_clk_fall (cpu_clk_fall),
    .clk2m        (clk2m)
  );

  // --------------------------------------------------
  // memory card port, held in reset with the system
  // --------------------------------------------------
  x1_spi_port #(.io_base(spi_base)) spi_port_i
  (
    .clk32M    (clk32M),
    .sys_reset (sys_reset),   // stretched reset, also covers ipl key
    .io_addr   (io_addr),
    .io_wdata  (io_wdata),
    .io_req    (io_req),
    .io_rd     (io_rd),
    .io_wr     (io_wr),
    .io_rdata  (io_rdata),
    .mmc_clk   (mmc_clk),
    .mmc_cs_n  (mmc_cs_n),
    .mmc_dout  (mmc_dout),
    .mmc_din   (mmc_din)
  );

endmodule : x1_core_top

//--- rtl/x1_pkg.sv
// shared constants for the x1 clock front end and card port, widths assume an 8-bit z80-style bus

package x1_pkg;

  // --------------------------------------------------
  // processor bus
  // --------------------------------------------------
  localparam int addr_w = 16;             // io address width
  localparam int data_w = 8;              // io data width

  // idle value on the read bus, wired-and style pull-up
  localparam logic [data_w-1:0] busfree = 8'hff;

  // --------------------------------------------------
  // prescaler
  // --------------------------------------------------
  // phases compared against the low 3 bits of the phase counter
  localparam logic [2:0] clk_rise_phase = 3'd6;   // rise strobe on the next cycle
  localparam logic [2:0] clk_fall_phase = 3'd2;   // fall strobe, 4 cycles after rise

  // stretch counter width, hold is 2**reset_hold_w cycles
  localparam int reset_hold_w = 4;

  // --------------------------------------------------
  // memory card port
  // --------------------------------------------------
  localparam int spi_cnt_w = 4;           // bit count from addr[3:0]

  // port base, only bits 15..7 take part in the decode
  localparam logic [addr_w-1:0] spi_io_base = 16'h0e80;

endpackage : x1_pkg

//--- rtl/x1_spi_port.sv
// bit-serial card port, lsb first receive, the write strobe is a level so no shift happens while held

`timescale 1ns/1ps

module x1_spi_port
#(
  parameter logic [x1_pkg::addr_w-1:0] io_base = x1_pkg::spi_io_base  // 128-address window
)
(
  input  logic                      clk32M,     // 32 MHz master clock
  input  logic                      sys_reset,  // async active high
  input  logic [x1_pkg::addr_w-1:0] io_addr,    // io address
  input  logic [x1_pkg::data_w-1:0] io_wdata,   // io write data
  input  logic                      io_req,     // io cycle active
  input  logic                      io_rd,      // read level
  input  logic                      io_wr,      // write level
  output logic [x1_pkg::data_w-1:0] io_rdata,   // read data, busfree when idle
  output logic                      mmc_clk,    // card clock
  output logic                      mmc_cs_n,   // card select, low active
  output logic                      mmc_dout,   // card data in (mosi)
  input  logic                      mmc_din     // card data out (miso)
);

  logic                         port_hit;   // addr[15:7] decode
  logic                         port_wr;    // write to the port, held level
  logic                         port_rd;    // read from the port
  logic                         spi_sel;    // stored card select
  logic [x1_pkg::spi_cnt_w-1:0] spi_cnt;    // bits left to move
  logic [x1_pkg::data_w-1:0]    spi_sreg;   // shift register
  logic                         spi_din;    // gated receive bit
  logic                         spi_busy;   // transfer in progress

  // --------------------------------------------------
  // io decode
  // --------------------------------------------------
  assign port_hit = (io_addr[x1_pkg::addr_w-1:7] == io_base[x1_pkg::addr_w-1:7]);
  assign port_wr  = io_req & io_wr & port_hit;
  assign port_rd  = io_req & io_rd & port_hit;

  // address layout of a write
  //   [3:0] bit count
  //   [4]   unused here, was the config rom select
  //   [5]   card select
  //   [6]   1 = keep shift register, 0 = load io_wdata

  // only the selected card may feed the shifter
  assign spi_din  = spi_sel & mmc_din;
  assign spi_busy = (spi_cnt != '0);

  // --------------------------------------------------
  // shift engine
  // --------------------------------------------------
  always_ff @(posedge clk32M or posedge sys_reset)
  begin
    if (sys_reset)
    begin
      mmc_clk  <= 1'b0;
      mmc_dout <= 1'b0;
      spi_sel  <= 1'b0;
      spi_cnt  <= '0;
      spi_sreg <= '0;
    end
    else
    begin
      // mosi follows bus data bit 0 while the clock is low
      if (!mmc_clk)
        mmc_dout <= io_wdata[0];

      if (port_wr)
      begin
        spi_cnt <= io_addr[x1_pkg::spi_cnt_w-1:0];   // reload every cycle of the write
        spi_sel <= io_addr[5];
        if (!io_addr[6])
          spi_sreg <= io_wdata;                      // tx byte
      end
      else if (spi_busy)
      begin
        mmc_clk <= ~mmc_clk;                         // two cycles per bit
        if (!mmc_clk)
          spi_sreg <= {spi_din, spi_sreg[x1_pkg::data_w-1:1]};  // rising, lsb first in
        else
          spi_cnt <= spi_cnt - 1'b1;                 // falling, bit done
      end
    end
  end

  // --------------------------------------------------
  // card pins and read data
  // --------------------------------------------------
  assign mmc_cs_n = ~spi_sel;

  // read returns the shifter in the same cycle
  always_comb
  begin
    if (port_rd)
      io_rdata = spi_sreg;
    else
      io_rdata = x1_pkg::busfree;
  end

endmodule : x1_spi_port

//--- tb/x1_core_sva.sv
// bound into x1_core_top as a pure observer and assumes ipl_n stays high for 16 cycles after reset

`timescale 1ns/1ps

module x1_core_sva
(
  input logic       clk32M,
  input logic       clk_reset,
  input logic       ipl_n,
  input logic       sys_reset,
  input logic       cpu_clk,
  input logic       cpu_clk_rise,
  input logic       cpu_clk_fall,
  input logic       clk2m,
  input logic [7:0] io_wdata,
  input logic       mmc_clk,
  input logic       mmc_dout
);

  int fail_cnt = 0;  // assertion failures so far

  // --------------------------------------------------
  // reset stretcher
  // --------------------------------------------------
  reset_hold_a : assert property (@(posedge clk32M)
    $fell(clk_reset) |-> sys_reset [*16] ##1 !sys_reset)
  else
  begin
    $error("sys_reset not released exactly 16 edges after clk_reset");
    fail_cnt++;
  end

  ipl_reset_a : assert property (@(posedge clk32M) !ipl_n |-> sys_reset)
  else
  begin
    $error("sys_reset low while ipl_n pressed");
    fail_cnt++;
  end

  // --------------------------------------------------
  // cpu clock strobes and 2 MHz level
  // --------------------------------------------------
  rise_period_a : assert property (@(posedge clk32M) disable iff (clk_reset)
    cpu_clk_rise |=> !cpu_clk_rise [*7] ##1 cpu_clk_rise)
  else
  begin
    $error("cpu_clk_rise period is not 8 cycles");
    fail_cnt++;
  end

  // fall strobe sits half a cpu period behind the rise
  fall_after_rise_a : assert property (@(posedge clk32M) disable iff (clk_reset)
    cpu_clk_rise |=> !cpu_clk_fall [*3] ##1 cpu_clk_fall)
  else
  begin
    $error("cpu_clk_fall not 4 cycles after cpu_clk_rise");
    fail_cnt++;
  end

  cpu_level_a : assert property (@(posedge clk32M) disable iff (clk_reset)
    (cpu_clk_rise |=> cpu_clk) and (cpu_clk_fall |=> !cpu_clk))
  else
  begin
    $error("cpu_clk does not follow its strobes");
    fail_cnt++;
  end

  clk2m_half_a : assert property (@(posedge clk32M) disable iff (clk_reset)
    ($rose(clk2m) |=> clk2m [*7] ##1 !clk2m) and ($fell(clk2m) |=> !clk2m [*7] ##1 clk2m))
  else
  begin
    $error("clk2m half period is not 8 cycles");
    fail_cnt++;
  end

  // --------------------------------------------------
  // mosi follows bus bit 0 only while mmc_clk is low
  // --------------------------------------------------
  mosi_sample_a : assert property (@(posedge clk32M) disable iff (sys_reset)
    (!$past(sys_reset) && !$past(mmc_clk)) |-> mmc_dout == $past(io_wdata[0]))
  else
  begin
    $error("mmc_dout did not take io_wdata[0] while mmc_clk low");
    fail_cnt++;
  end

  mosi_hold_a : assert property (@(posedge clk32M) disable iff (sys_reset)
    (!$past(sys_reset) && $past(mmc_clk)) |-> mmc_dout == $past(mmc_dout))
  else
  begin
    $error("mmc_dout changed while mmc_clk high");
    fail_cnt++;
  end

endmodule : x1_core_sva

bind x1_core_top x1_core_sva sva_i
(
  .clk32M       (clk32M),
  .clk_reset    (clk_reset),
  .ipl_n        (ipl_n),
  .sys_reset    (sys_reset),
  .cpu_clk      (cpu_clk),
  .cpu_clk_rise (cpu_clk_rise),
  .cpu_clk_fall (cpu_clk_fall),
  .clk2m        (clk2m),
  .io_wdata     (io_wdata),
  .mmc_clk      (mmc_clk),
  .mmc_dout     (mmc_dout)
);

//--- tb/x1_core_tb.sv
// the card is a behavioral lsb-first model and transfers use only 1 to 8 bits

`timescale 1ns/1ps

module x1_core_tb;

  localparam logic [15:0] port_base      = x1_pkg::spi_io_base;
  localparam int          timeout_cycles = 2000;  // tests need roughly 260 cycles

  logic        clk32M;
  logic        clk_reset;
  logic        ipl_n;
  logic        sys_reset;
  logic        cpu_clk;
  logic        cpu_clk_rise;
  logic        cpu_clk_fall;
  logic        clk2m;
  logic [15:0] io_addr;
  logic [7:0]  io_wdata;
  logic        io_req;
  logic        io_rd;
  logic        io_wr;
  logic [7:0]  io_rdata;
  logic        mmc_clk;
  logic        mmc_cs_n;
  logic        mmc_dout;
  logic        mmc_din;

  int         err_cnt      = 0;   // immediate assertion failures
  int         tests_passed = 0;
  int         tests_failed = 0;
  int         fails_before = 0;   // failure total when the current test began
  int         cycle_cnt    = 0;
  logic [7:0] sreg_exp     = '0;  // expected shift register
  logic [7:0] card_byte    = '0;  // byte the card sends
  int         card_idx     = 0;   // bit currently on mmc_din

  x1_core_top #(.spi_base(port_base)) x1_core_top_i
  (
    .clk32M       (clk32M),
    .clk_reset    (clk_reset),
    .ipl_n        (ipl_n),
    .sys_reset    (sys_reset),
    .cpu_clk      (cpu_clk),
    .cpu_clk_rise (cpu_clk_rise),
    .cpu_clk_fall (cpu_clk_fall),
    .clk2m        (clk2m),
    .io_addr      (io_addr),
    .io_wdata     (io_wdata),
    .io_req       (io_req),
    .io_rd        (io_rd),
    .io_wr        (io_wr),
    .io_rdata     (io_rdata),
    .mmc_clk      (mmc_clk),
    .mmc_cs_n     (mmc_cs_n),
    .mmc_dout     (mmc_dout),
    .mmc_din      (mmc_din)
  );

  initial
  begin
    clk32M = 1'b0;
    forever #20 clk32M = ~clk32M;  // 40 ns period
  end

  // --------------------------------------------------
  // card model presents the next bit after each falling card clock
  // --------------------------------------------------
  always @(negedge mmc_clk)
  begin
    card_idx = card_idx + 1;
    if (card_idx < 8)
      mmc_din <= card_byte[card_idx];
    else
      mmc_din <= 1'b0;               // nothing left to send
  end

  task automatic card_load(input logic [7:0] b);
    card_byte = b;
    card_idx  = 0;
    mmc_din  <= b[0];                // bit 0 goes out first
  endtask

  function automatic int total_fails();
    return err_cnt + x1_core_top_i.sva_i.fail_cnt;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAILED at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic finish_test(input string name);
    int now_fails;
    now_fails = total_fails();
    if (now_fails == fails_before)
    begin
      tests_passed++;
      $display("test %s: ok", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, now_fails - fails_before);
    end
    fails_before = now_fails;
  endtask

  // --------------------------------------------------
  // io bus cycles
  // --------------------------------------------------
  task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
    @(posedge clk32M);
    io_addr  <= addr;
    io_wdata <= data;
    io_req   <= 1'b1;
    io_wr    <= 1'b1;
    @(posedge clk32M);               // write held for one cycle
    io_req   <= 1'b0;
    io_wr    <= 1'b0;
  endtask

  task automatic io_read_expect(input logic [15:0] addr, input logic [7:0] exp);
    @(posedge clk32M);
    io_addr <= addr;
    io_req  <= 1'b1;
    io_rd   <= 1'b1;
    @(negedge clk32M);               // read data is combinational
    expect_eq("io_rdata", io_rdata, exp);
    @(posedge clk32M);
    io_req  <= 1'b0;
    io_rd   <= 1'b0;
  endtask

  // card bit i ends up at bit 8-n+i and the tx byte moves down by n
  function automatic logic [7:0] shift_expect(input logic [7:0] start, input logic [7:0] card,
                                              input int n, input logic sel);
    logic [7:0] val;
    val = start >> n;
    for (int i = 0; i < n; i++)
      val[8 - n + i] = sel ? card[i] : 1'b0;
    return val;
  endfunction

  task automatic run_transfer(input int n, input logic sel, input logic [7:0] tx,
                              input logic [7:0] card);
    int          toggles;
    logic        prev_clk;
    logic [15:0] addr;
    toggles  = 0;
    prev_clk = 1'b0;
    addr     = port_base | (16'(sel) << 5) | 16'(n);  // bit 6 clear so the tx byte loads
    card_load(card);
    io_write(addr, tx);
    repeat (2 * n + 6)               // 2n toggles plus idle margin
    begin
      @(negedge clk32M);
      if (mmc_clk != prev_clk)
        toggles++;
      prev_clk = mmc_clk;
      @(posedge clk32M);
      io_wdata <= 8'($urandom);      // keeps mosi busy
    end
    expect_eq("mmc_clk toggles", toggles, 2 * n);
    expect_eq("mmc_clk", mmc_clk, 1'b0);
    expect_eq("mmc_cs_n", mmc_cs_n, !sel);
    sreg_exp = shift_expect(tx, card, n, sel);
    io_read_expect(port_base, sreg_exp);
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------
  initial
  begin : stimulus
    int         edges;
    int         rises;
    int         flips;
    logic       prev_2m;
    logic [7:0] keep_val;
    logic [7:0] tx;
    void'($urandom(32'h9d598871));
    clk_reset = 1'b1;
    ipl_n     = 1'b1;
    io_addr   = '0;
    io_wdata  = '0;
    io_req    = 1'b0;
    io_rd     = 1'b0;
    io_wr     = 1'b0;
    mmc_din   = 1'b0;
    repeat (2) @(posedge clk32M);
    clk_reset <= 1'b0;

    // reset stretch followed by the ipl key
    edges = 0;
    while (sys_reset && edges < 40)
    begin
      @(posedge clk32M);
      edges++;
      @(negedge clk32M);
    end
    expect_eq("sys_reset hold edges", edges, 16);
    @(posedge clk32M);
    ipl_n <= 1'b0;
    repeat (3)
    begin
      @(negedge clk32M);
      expect_eq("sys_reset", sys_reset, 1'b1);
    end
    @(posedge clk32M);
    ipl_n <= 1'b1;
    @(negedge clk32M);
    expect_eq("sys_reset", sys_reset, 1'b0);
    finish_test("reset stretch");

    // four cpu periods
    rises   = 0;
    flips   = 0;
    prev_2m = clk2m;
    repeat (32)
    begin
      @(negedge clk32M);
      if (cpu_clk_rise)
        rises++;
      if (clk2m != prev_2m)
        flips++;
      prev_2m = clk2m;
    end
    expect_eq("cpu_clk_rise pulses", rises, 4);
    expect_eq("clk2m changes", flips, 4);
    finish_test("cpu clock strobes");

    repeat (4)
      run_transfer(1 + ($urandom % 8), 1'($urandom), 8'($urandom), 8'($urandom));
    finish_test("transfer length");

    run_transfer(8, 1'b1, 8'($urandom), 8'($urandom));  // card byte lands whole
    run_transfer(8, 1'b0, 8'($urandom), 8'($urandom));  // deselected so zeros shift in
    finish_test("receive data");

    keep_val = sreg_exp;
    io_write(port_base | 16'h0040, 8'($urandom));       // bit 6 set so no load
    io_read_expect(port_base, keep_val);
    tx = 8'($urandom);
    io_write(port_base, tx);
    io_read_expect(port_base, tx);
    io_read_expect(port_base ^ 16'h0080, 8'hff);         // just outside the window
    io_read_expect(port_base ^ 16'h8000, 8'hff);
    finish_test("load control and bus free");

    run_transfer(5, 1'b1, 8'($urandom), 8'($urandom));
    finish_test("mosi sampling");

    $display("tests ok: %0d, tests with errors: %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && total_fails() == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

  // watchdog
  initial
  begin : watchdog
    while (cycle_cnt < timeout_cycles)
    begin
      @(posedge clk32M);
      cycle_cnt++;
    end
    $display("timeout, tests did not finish within %0d cycles", timeout_cycles);
    $display("Simulation failed");
    $finish;
  end

endmodule : x1_core_tb
